// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = session_tb
FILELIST  = project.f
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== hdl/master_cmd_gen.sv ====
module master_cmd_gen (
    input  logic clk,
    input  logic rstN,
    input  session_pkg::main_state_t state,
    input  logic latch_sid,
    input  logic latch_rw,
    input  logic latch_ext,
    input  logic next_addr,
    input  logic [session_pkg::DATA_W-1:0] sw,
    input  logic cfg_load,
    input  logic [session_pkg::M_IDX_W-1:0] cfg_master,
    input  session_pkg::cfg_state_t cfg_kind,
    input  logic [session_pkg::DATA_W-1:0] rword,
    input  logic [session_pkg::N_MASTERS-1:0][session_pkg::ADDR_W-1:0] first_addr,
    input  logic [session_pkg::N_MASTERS-1:0][session_pkg::ADDR_W-1:0] last_addr,
    input  logic comm_go,
    input  logic none_selected,
    output session_pkg::master_cmd_t [session_pkg::N_MASTERS-1:0] cmd,
    output logic [session_pkg::N_MASTERS-1:0] start,
    output logic [session_pkg::N_MASTERS-1:0] eoc
);
    import session_pkg::*;

    logic in_ext;
    logic [M_IDX_W-1:0] wm; // master whose words are being entered
    logic [N_MASTERS-1:0] adv_seen;

    assign in_ext = state inside {ext_write_m0, ext_write_both, ext_write_m1};
    assign wm     = M_IDX_W'(state == ext_write_m1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmd <= '0;
            start <= '0;
            eoc <= '0;
            adv_seen <= '0;
        end else begin
            start <= '0; // start and eoc are single-cycle pulses
            eoc <= '0;
            for (int m = 0; m < N_MASTERS; m++) begin
                if (latch_sid) cmd[m].slave_id <= sw[SID_W*m +: SID_W];
                if (latch_rw) cmd[m].rd_wr <= sw[m];
                if (latch_ext) cmd[m].ext_write <= sw[m];
                if (state == comm_done) cmd[m].address <= sw[ADDR_W-1:0]; // readback address
            end
            if (in_ext && next_addr) begin
                if (adv_seen[wm]) cmd[wm].burst <= 1'b1; // second word makes it a burst
                adv_seen[wm] <= 1'b1;
            end
            if (none_selected) eoc <= '1;
            if (cfg_load) begin
                case (cfg_kind)
                    cfg_start: begin
                        start[cfg_master] <= 1'b1;
                        cmd[cfg_master].address <= first_addr[cfg_master];
                        cmd[cfg_master].data <= rword;
                    end
                    cfg_middle: cmd[cfg_master].data <= rword;
                    cfg_last: begin
                        start[cfg_master] <= 1'b1;
                        cmd[cfg_master].address <= last_addr[cfg_master];
                        cmd[cfg_master].data <= rword;
                    end
                    default: begin
                        for (int m = 0; m < N_MASTERS; m++) cmd[m].address <= '0;
                    end
                endcase
            end
            if (comm_go) start <= '1; // both masters start together
        end
    end

endmodule

// ==== hdl/range_calc.sv ====
module range_calc (
    input  logic clk,
    input  logic rstN,
    input  logic latch_first,
    input  logic latch_len,
    input  logic [session_pkg::M_IDX_W-1:0] master,
    input  logic [session_pkg::ADDR_W-1:0] sw,
    input  logic [session_pkg::N_MASTERS-1:0][session_pkg::SID_W-1:0] slave_id,
    output logic [session_pkg::N_MASTERS-1:0][session_pkg::ADDR_W-1:0] first_addr,
    output logic [session_pkg::N_MASTERS-1:0][session_pkg::ADDR_W-1:0] last_addr
);
    import session_pkg::*;

    logic [SID_W-1:0] sid;
    logic [ADDR_W:0] sum; // one extra bit so the overrun is visible
    logic [ADDR_W-1:0] clamped;
    int depth;

    assign sid = slave_id[master];
    assign sum = {1'b0, first_addr[master]} + {1'b0, sw};

    always_comb begin
        depth = SLAVE_DEPTH[(sid == '0) ? 2'd0 : sid - 2'd1];
        if (sum > depth - 1) clamped = ADDR_W'(depth - 1); // stop at the slave's top word
        else clamped = sum[ADDR_W-1:0];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            first_addr <= '0;
            last_addr <= '0;
        end else begin
            if (latch_first) first_addr[master] <= sw;
            if (latch_len) last_addr[master] <= clamped;
        end
    end

endmodule

// ==== hdl/session_ctrl.sv ====
module session_ctrl #(
    parameter int BANK_DEPTH = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic step,
    input  logic next_addr,
    input  logic [session_pkg::DATA_W-1:0] sw,
    input  logic [session_pkg::N_MASTERS-1:0][$clog2(BANK_DEPTH+1)-1:0] word_count,
    input  session_pkg::master_status_t [session_pkg::N_MASTERS-1:0] status,
    input  logic [session_pkg::N_MASTERS-1:0][session_pkg::SID_W-1:0] slave_id,
    output session_pkg::main_state_t state,
    output logic bank_wr,
    output logic [session_pkg::M_IDX_W-1:0] bank_sel,
    output logic bank_clear_ptr,
    output logic latch_sid,
    output logic latch_rw,
    output logic latch_ext,
    output logic latch_first,
    output logic latch_len,
    output logic cfg_load,
    output logic [session_pkg::M_IDX_W-1:0] cfg_master,
    output session_pkg::cfg_state_t cfg_kind,
    output logic [$clog2(BANK_DEPTH)-1:0] cfg_index,
    output logic comm_go,
    output logic none_selected
);
    import session_pkg::*;

    localparam int IDX_W = $clog2(BANK_DEPTH);
    localparam int CLK_W = $clog2(CFG_CLKS);

    main_state_t state_next;
    cfg_state_t cfg_q, cfg_next;
    logic [M_IDX_W-1:0] master_q, master_next;
    logic [IDX_W-1:0] idx_q, idx_next, last_idx;
    logic [CLK_W-1:0] clk_cnt;
    logic [$clog2(BANK_DEPTH+1)-1:0] cnt_m;
    logic sub_end, all_done;

    assign cnt_m    = word_count[master_q];
    assign last_idx = (cnt_m == '0) ? '0 : IDX_W'(cnt_m - 1'b1); // index of last stored word
    assign sub_end  = (clk_cnt == CLK_W'(CFG_CLKS - 1));
    assign bank_sel = M_IDX_W'(state inside {ext_write_m1, start_sel_m1, length_sel_m1});

    always_comb begin
        all_done = 1'b1;
        for (int m = 0; m < N_MASTERS; m++) begin
            if (slave_id[m] != '0 && !status[m].done_com) all_done = 1'b0; // idle masters ignored
        end
    end

    always_comb begin
        state_next = state;
        cfg_next = cfg_q;
        master_next = master_q;
        idx_next = idx_q;
        {bank_wr, bank_clear_ptr, latch_sid, latch_rw, latch_ext} = '0;
        {latch_first, latch_len, cfg_load, comm_go, none_selected} = '0;
        case (state)
            slave_sel: if (step) begin
                latch_sid = 1'b1;
                if (sw[3:0] == '0) begin
                    none_selected = 1'b1; // nothing to talk to, skip the session
                    state_next = comm_done;
                end else begin
                    state_next = rw_sel;
                end
            end
            rw_sel: if (step) begin
                latch_rw = 1'b1;
                state_next = ext_sel;
            end
            ext_sel: if (step) begin
                latch_ext = 1'b1;
                case (ext_sel_t'(sw[1:0]))
                    ext_m0:   state_next = ext_write_m0;
                    ext_m1:   state_next = ext_write_m1;
                    ext_both: state_next = ext_write_both;
                    default:  state_next = start_sel_m0;
                endcase
            end
            ext_write_m0, ext_write_both, ext_write_m1: begin
                bank_wr = next_addr; // word stored as the operator moves on
                if (step) begin
                    bank_clear_ptr = 1'b1;
                    state_next = (state == ext_write_both) ? ext_write_m1 : start_sel_m0;
                end
            end
            start_sel_m0: if (step) begin
                latch_first = 1'b1;
                state_next = start_sel_m1;
            end
            start_sel_m1: if (step) begin
                latch_first = 1'b1;
                state_next = length_sel_m0;
            end
            length_sel_m0: if (step) begin
                latch_len = 1'b1;
                state_next = length_sel_m1;
            end
            length_sel_m1: if (step) begin
                latch_len = 1'b1;
                state_next = config_masters;
                cfg_load = 1'b1; // first cfg_start pulse goes out on this edge
                cfg_next = cfg_start;
                master_next = '0;
                idx_next = '0;
            end
            config_masters: begin
                if (cfg_q == cfg_done) begin
                    state_next = comm_ready;
                end else if (sub_end) begin
                    cfg_load = 1'b1;
                    case (cfg_q)
                        cfg_start: begin
                            cfg_next = (cnt_m > 2) ? cfg_middle : cfg_last;
                            idx_next = (cnt_m > 2) ? IDX_W'(1) : last_idx;
                        end
                        cfg_middle: begin
                            idx_next = idx_q + 1'b1;
                            cfg_next = (idx_q + 1'b1 == last_idx) ? cfg_last : cfg_middle;
                        end
                        default: begin
                            if (master_q == M_IDX_W'(N_MASTERS - 1)) begin
                                cfg_next = cfg_done;
                            end else begin
                                master_next = master_q + 1'b1; // on to the next master
                                idx_next = '0;
                                cfg_next = cfg_start;
                            end
                        end
                    endcase
                end
            end
            comm_ready: if (step) begin
                comm_go = 1'b1;
                state_next = communicating;
            end
            communicating: if (all_done) state_next = comm_done;
            default: ; // comm_done holds until reset
        endcase
        cfg_kind = cfg_next;
        cfg_master = master_next;
        cfg_index = idx_next;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= slave_sel;
            cfg_q <= cfg_start;
            master_q <= '0;
            idx_q <= '0;
            clk_cnt <= '0;
        end else begin
            state <= state_next;
            cfg_q <= cfg_next;
            master_q <= master_next;
            idx_q <= idx_next;
            if (cfg_load) clk_cnt <= '0;
            else if (state == config_masters) clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/session_pkg.sv ====
`include "session_defs.svh"

package session_pkg;

    localparam int DATA_W    = `DATA_W;
    localparam int ADDR_W    = `ADDR_W;
    localparam int N_MASTERS = 2;
    localparam int M_IDX_W   = $clog2(N_MASTERS);
    localparam int SID_W     = 2; // id 0 means no slave
    localparam int CFG_CLKS  = 2; // cycles per configuration step

    localparam int SLAVE_DEPTH [3] = '{2048, 2048, 1024}; // by slave id minus one

    typedef enum logic [3:0] {
        slave_sel, rw_sel, ext_sel,
        ext_write_m0, ext_write_both, ext_write_m1,
        start_sel_m0, start_sel_m1,
        length_sel_m0, length_sel_m1,
        config_masters, comm_ready, communicating, comm_done
    } main_state_t;

    typedef enum logic [1:0] {cfg_start, cfg_middle, cfg_last, cfg_done} cfg_state_t;

    typedef enum logic [1:0] {ext_none, ext_m0, ext_m1, ext_both} ext_sel_t;

    typedef struct packed {
        logic [SID_W-1:0]  slave_id;
        logic              rd_wr;     // 1 is write
        logic              ext_write;
        logic              burst;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
    } master_cmd_t;

    typedef struct packed {
        logic              done_com;
        logic [DATA_W-1:0] data_out;
    } master_status_t;

endpackage

// ==== hdl/session_top.sv ====
module session_top #(
    parameter int BANK_DEPTH = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic step,
    input  logic next_addr,
    input  logic [session_pkg::DATA_W-1:0] sw,
    output session_pkg::master_cmd_t [session_pkg::N_MASTERS-1:0] cmd,
    output logic [session_pkg::N_MASTERS-1:0] start,
    output logic [session_pkg::N_MASTERS-1:0] eoc,
    input  session_pkg::master_status_t [session_pkg::N_MASTERS-1:0] status,
    output logic [3:0] state_leds,
    output logic [6:0] hex0,
    output logic [6:0] hex1
);
    import session_pkg::*;

    main_state_t state;
    cfg_state_t cfg_kind;
    logic bank_wr, bank_clear_ptr, latch_sid, latch_rw, latch_ext, latch_first, latch_len;
    logic cfg_load, comm_go, none_selected;
    logic [M_IDX_W-1:0] bank_sel, cfg_master;
    logic [$clog2(BANK_DEPTH)-1:0] cfg_index;
    logic [N_MASTERS-1:0][$clog2(BANK_DEPTH+1)-1:0] word_count;
    logic [N_MASTERS-1:0][SID_W-1:0] slave_id;
    logic [N_MASTERS-1:0][ADDR_W-1:0] first_addr, last_addr;
    logic [DATA_W-1:0] rword;

    for (genvar m = 0; m < N_MASTERS; m++) begin : g_sid
        assign slave_id[m] = cmd[m].slave_id;
    end

    session_ctrl #(.BANK_DEPTH(BANK_DEPTH)) u_ctrl (
        .clk, .rstN, .step, .next_addr, .sw, .word_count, .status, .slave_id,
        .state, .bank_wr, .bank_sel, .bank_clear_ptr, .latch_sid, .latch_rw,
        .latch_ext, .latch_first, .latch_len, .cfg_load, .cfg_master, .cfg_kind,
        .cfg_index, .comm_go, .none_selected
    );

    write_bank #(.BANK_DEPTH(BANK_DEPTH)) u_bank (
        .clk, .rstN, .wr(bank_wr), .sel(bank_sel), .clear_ptr(bank_clear_ptr),
        .advance(next_addr), .wdata(sw), .rd_master(cfg_master), .rd_index(cfg_index),
        .word_count, .rword
    );

    range_calc u_range (
        .clk, .rstN, .latch_first, .latch_len, .master(bank_sel),
        .sw(sw[ADDR_W-1:0]), .slave_id, .first_addr, .last_addr
    );

    master_cmd_gen u_cmd (
        .clk, .rstN, .state, .latch_sid, .latch_rw, .latch_ext, .next_addr, .sw,
        .cfg_load, .cfg_master, .cfg_kind, .rword, .first_addr, .last_addr,
        .comm_go, .none_selected, .cmd, .start, .eoc
    );

    status_display u_disp (
        .clk, .rstN, .state, .status, .state_leds, .hex0, .hex1
    );

endmodule

// ==== hdl/status_display.sv ====
module status_display (
    input  logic clk,
    input  logic rstN,
    input  session_pkg::main_state_t state,
    input  session_pkg::master_status_t [session_pkg::N_MASTERS-1:0] status,
    output logic [3:0] state_leds,
    output logic [6:0] hex0,
    output logic [6:0] hex1
);
    import session_pkg::*;

    localparam logic [6:0] BLANK = 7'h7f; // all segments off

    function automatic logic [6:0] seg7(input logic [3:0] v);
        case (v) // gfedcba, low lights the segment
            4'h0: seg7 = 7'b1000000;
            4'h1: seg7 = 7'b1111001;
            4'h2: seg7 = 7'b0100100;
            4'h3: seg7 = 7'b0110000;
            4'h4: seg7 = 7'b0011001;
            4'h5: seg7 = 7'b0010010;
            4'h6: seg7 = 7'b0000010;
            4'h7: seg7 = 7'b1111000;
            4'h8: seg7 = 7'b0000000;
            4'h9: seg7 = 7'b0010000;
            4'ha: seg7 = 7'b0001000;
            4'hb: seg7 = 7'b0000011;
            4'hc: seg7 = 7'b1000110;
            4'hd: seg7 = 7'b0100001;
            4'he: seg7 = 7'b0000110;
            default: seg7 = 7'b0001110;
        endcase
    endfunction

    assign state_leds = {state == communicating, state == comm_done,
                         state == comm_ready, state == slave_sel};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hex0 <= BLANK;
            hex1 <= BLANK;
        end else if (state == comm_done) begin
            hex0 <= seg7(status[0].data_out[3:0]);
            hex1 <= seg7(status[0].data_out[7:4]);
        end else begin
            hex0 <= BLANK;
            hex1 <= BLANK;
        end
    end

endmodule

// ==== hdl/write_bank.sv ====
module write_bank #(
    parameter int BANK_DEPTH = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic wr,
    input  logic [session_pkg::M_IDX_W-1:0] sel,
    input  logic clear_ptr,
    input  logic advance,
    input  logic [session_pkg::DATA_W-1:0] wdata,
    input  logic [session_pkg::M_IDX_W-1:0] rd_master,
    input  logic [$clog2(BANK_DEPTH)-1:0] rd_index,
    output logic [session_pkg::N_MASTERS-1:0][$clog2(BANK_DEPTH+1)-1:0] word_count,
    output logic [session_pkg::DATA_W-1:0] rword
);
    import session_pkg::*;

    logic [DATA_W-1:0] mem [N_MASTERS][BANK_DEPTH];
    logic [$clog2(BANK_DEPTH)-1:0] ptr; // shared by both masters
    logic full;

    assign full  = (word_count[sel] == BANK_DEPTH);
    assign rword = mem[rd_master][rd_index];

    always_ff @(posedge clk) begin
        if (wr && !full) mem[sel][ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ptr <= '0;
            word_count <= '0;
        end else if (clear_ptr) begin
            ptr <= '0; // next master starts at word 0
        end else if (wr && advance && !full) begin
            ptr <= ptr + 1'b1;
            word_count[sel] <= word_count[sel] + 1'b1; // saturates through full
        end
    end

endmodule

// ==== include/session_defs.svh ====
`ifndef SESSION_DEFS_SVH
`define SESSION_DEFS_SVH

`define DATA_W 16 // switch and bus data word
`define ADDR_W 12 // wide enough for the largest slave

`endif

// ==== project.f ====
+incdir+include
hdl/session_pkg.sv
hdl/session_ctrl.sv
hdl/write_bank.sv
hdl/range_calc.sv
hdl/master_cmd_gen.sv
hdl/status_display.sv
hdl/session_top.sv
sim/session_assertions.sv
sim/session_tb.sv

// ==== sim/session_assertions.sv ====
module session_assertions (
    input logic clk,
    input logic rstN,
    input logic [session_pkg::N_MASTERS-1:0] start,
    input logic [session_pkg::N_MASTERS-1:0] eoc,
    input logic [3:0] state_leds
);
    timeunit 1ns;
    timeprecision 100ps;
    import session_pkg::*;

    for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
        start_not_with_eoc: assert property (
            @(posedge clk) disable iff (!rstN) !(start[m] && eoc[m])
        ) else $error("start and eoc high together for master %0d", m);

        start_one_cycle: assert property (
            @(posedge clk) disable iff (!rstN) start[m] |=> !start[m]
        ) else $error("start held for two cycles on master %0d", m);
    end

    one_state_led: assert property (
        @(posedge clk) disable iff (!rstN) $onehot0(state_leds)
    ) else $error("more than one state indicator lit, state_leds %b", state_leds);

endmodule

bind session_top session_assertions u_assertions (
    .clk(clk), .rstN(rstN), .start(start), .eoc(eoc), .state_leds(state_leds)
);

// ==== sim/session_tb.sv ====
module session_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import session_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int MAX_CYCLES = 3000; // longest test is under 200 cycles
    localparam int MAX_REC = 8;
    localparam int N_WORDS = 3;
    localparam int SLAVE_WORDS [3] = '{2048, 2048, 1024};
    localparam logic [DATA_W-1:0] FIRST0 = 16'h0100;
    localparam logic [DATA_W-1:0] FIRST1 = 16'h0300;
    localparam logic [DATA_W-1:0] LEN0 = 16'h0020;
    localparam logic [DATA_W-1:0] LEN1 = 16'h0200; // runs past the end of slave 3

    logic clk, rstN, step, next_addr, comm_armed;
    logic [DATA_W-1:0] sw;
    master_cmd_t [N_MASTERS-1:0] cmd;
    logic [N_MASTERS-1:0] start, eoc;
    master_status_t [N_MASTERS-1:0] status;
    logic [3:0] state_leds;
    logic [6:0] hex0, hex1;
    logic [DATA_W-1:0] words [N_WORDS];
    int cycle, errors, tests_run;
    int n_start [N_MASTERS];
    int n_eoc [N_MASTERS];
    int done_wait [N_MASTERS];
    int rec_cyc [N_MASTERS][MAX_REC];
    master_cmd_t rec_cmd [N_MASTERS][MAX_REC];

    session_top dut0 (
        .clk, .rstN, .step, .next_addr, .sw, .cmd, .start, .eoc, .status,
        .state_leds, .hex0, .hex1
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never reached the awaited state", cycle);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // master models, looking at the outputs just after each edge
    always @(posedge clk) begin
        #1;
        for (int m = 0; m < N_MASTERS; m++) begin
            if (done_wait[m] > 0) begin
                done_wait[m]--;
                if (done_wait[m] == 0) begin
                    status[m].done_com = 1'b1; // stays high until reset
                    status[m].data_out = DATA_W'($urandom);
                end
            end
            if (start[m]) begin
                if (n_start[m] < MAX_REC) begin
                    rec_cyc[m][n_start[m]] = cycle;
                    rec_cmd[m][n_start[m]] = cmd[m];
                end
                n_start[m]++;
                if (comm_armed) done_wait[m] = 2 + int'($urandom % 7);
            end
            if (eoc[m]) n_eoc[m]++;
        end
    end

    function automatic logic [6:0] lit_segments(input logic [3:0] v);
        logic [6:0] lit [16]; // gfedcba, one means the segment is on
        lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
        return lit[v];
    endfunction

    function automatic int expected_last(input int first, input int len, input int sid);
        int top;
        top = SLAVE_WORDS[sid-1] - 1;
        if (first + len > top) return top;
        return first + len;
    endfunction

    task automatic report_mismatch(input string sig, input logic [95:0] got,
                                   input logic [95:0] exp);
        errors++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, sig, got, exp);
    endtask

    task automatic end_test(input string name, input int err_at_start);
        tests_run++;
        if (errors == err_at_start) $display("test %-16s ok", name);
        else $display("test %-16s %0d error(s)", name, errors - err_at_start);
    endtask

    task automatic apply_reset();
        rstN = 1'b0;
        comm_armed = 1'b0;
        @(posedge clk);
        status = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            n_start[m] = 0;
            n_eoc[m] = 0;
            done_wait[m] = 0;
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic press_step(input logic [DATA_W-1:0] val);
        sw = val;
        step = 1'b1;
        @(posedge clk);
        #1;
        step = 1'b0;
    endtask

    task automatic enter_word(input logic [DATA_W-1:0] val);
        sw = val;
        next_addr = 1'b1;
        @(posedge clk);
        #1;
        next_addr = 1'b0;
    endtask

    task automatic wait_for_led(input int idx);
        while (!state_leds[idx]) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_reset_values();
        int err0;
        err0 = errors;
        if (state_leds !== 4'b0001) report_mismatch("state_leds", state_leds, 4'b0001);
        if (start !== '0) report_mismatch("start", start, 0);
        if (eoc !== '0) report_mismatch("eoc", eoc, 0);
        if (cmd !== '0) report_mismatch("cmd", cmd, 0);
        if (hex0 !== 7'h7f) report_mismatch("hex0", hex0, 7'h7f);
        if (hex1 !== 7'h7f) report_mismatch("hex1", hex1, 7'h7f);
        end_test("reset values", err0);
    endtask

    task automatic check_empty_session();
        int err0;
        err0 = errors;
        press_step(16'($urandom) & 16'hfff0); // no slave for either master
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        for (int m = 0; m < N_MASTERS; m++) begin
            if (n_eoc[m] != 1) report_mismatch($sformatf("eoc pulses m%0d", m), n_eoc[m], 1);
            if (n_start[m] != 0) report_mismatch($sformatf("start pulses m%0d", m), n_start[m], 0);
        end
        if (state_leds !== 4'b0100) report_mismatch("state_leds", state_leds, 4'b0100);
        end_test("empty session", err0);
    endtask

    task automatic run_full_session();
        int err0, spacing;
        err0 = errors;
        for (int i = 0; i < N_WORDS; i++) words[i] = DATA_W'($urandom);
        press_step(16'h000d); // m0 on slave 1, m1 on slave 3
        press_step(16'h0001); // m0 writes, m1 reads
        press_step(16'h0001); // external words for m0 only
        for (int i = 0; i < N_WORDS; i++) enter_word(words[i]);
        press_step('0);
        press_step(FIRST0);
        press_step(FIRST1);
        press_step(LEN0);
        press_step(LEN1);
        wait_for_led(1);
        spacing = (1 + ((N_WORDS > 2) ? N_WORDS - 2 : 0)) * CFG_CLKS;
        if (start !== '0) report_mismatch("start in comm_ready", start, 0);
        for (int m = 0; m < N_MASTERS; m++) begin
            if (cmd[m].address !== '0)
                report_mismatch($sformatf("cmd[%0d].address in comm_ready", m),
                                cmd[m].address, 0);
            if (n_eoc[m] != 0) report_mismatch($sformatf("eoc pulses m%0d", m), n_eoc[m], 0);
        end
        if (n_start[0] != 2) report_mismatch("start pulses m0", n_start[0], 2);
        if (n_start[1] != 2) report_mismatch("start pulses m1", n_start[1], 2);
        if (rec_cmd[0][0].address !== FIRST0[ADDR_W-1:0])
            report_mismatch("cmd[0].address first", rec_cmd[0][0].address, FIRST0);
        if (rec_cmd[0][0].data !== words[0])
            report_mismatch("cmd[0].data first", rec_cmd[0][0].data, words[0]);
        if ({rec_cmd[0][0].slave_id, rec_cmd[0][0].rd_wr, rec_cmd[0][0].ext_write,
             rec_cmd[0][0].burst} !== 5'b01111)
            report_mismatch("cmd[0] control fields", {rec_cmd[0][0].slave_id,
                rec_cmd[0][0].rd_wr, rec_cmd[0][0].ext_write, rec_cmd[0][0].burst}, 5'b01111);
        if (rec_cmd[0][1].address !== ADDR_W'(expected_last(FIRST0, LEN0, 1)))
            report_mismatch("cmd[0].address last", rec_cmd[0][1].address,
                            expected_last(FIRST0, LEN0, 1));
        if (rec_cmd[0][1].data !== words[N_WORDS-1])
            report_mismatch("cmd[0].data last", rec_cmd[0][1].data, words[N_WORDS-1]);
        if (rec_cyc[0][1] - rec_cyc[0][0] != spacing)
            report_mismatch("start spacing m0", rec_cyc[0][1] - rec_cyc[0][0], spacing);
        if (rec_cmd[1][0].address !== FIRST1[ADDR_W-1:0])
            report_mismatch("cmd[1].address first", rec_cmd[1][0].address, FIRST1);
        if ({rec_cmd[1][0].slave_id, rec_cmd[1][0].rd_wr, rec_cmd[1][0].ext_write,
             rec_cmd[1][0].burst} !== 5'b11000)
            report_mismatch("cmd[1] control fields", {rec_cmd[1][0].slave_id,
                rec_cmd[1][0].rd_wr, rec_cmd[1][0].ext_write, rec_cmd[1][0].burst}, 5'b11000);
        if (rec_cyc[1][0] - rec_cyc[0][1] != CFG_CLKS)
            report_mismatch("gap m0 last to m1 first", rec_cyc[1][0] - rec_cyc[0][1], CFG_CLKS);
        if (rec_cyc[1][1] - rec_cyc[1][0] != CFG_CLKS)
            report_mismatch("start spacing m1", rec_cyc[1][1] - rec_cyc[1][0], CFG_CLKS);
        end_test("full session", err0);
    endtask

    task automatic check_length_clamp();
        int err0, exp_last;
        err0 = errors;
        exp_last = expected_last(FIRST1, LEN1, 3);
        if (rec_cmd[1][1].address !== ADDR_W'(exp_last))
            report_mismatch("cmd[1].address last", rec_cmd[1][1].address, exp_last);
        end_test("length clamp", err0);
    endtask

    task automatic check_comm_done();
        int err0;
        logic [6:0] exp_hex0, exp_hex1;
        err0 = errors;
        comm_armed = 1'b1;
        press_step('0); // both masters start together
        if (state_leds !== 4'b1000) report_mismatch("state_leds", state_leds, 4'b1000);
        wait_for_led(2);
        for (int m = 0; m < N_MASTERS; m++) begin
            if (n_start[m] != 3) report_mismatch($sformatf("start pulses m%0d", m), n_start[m], 3);
            if (status[m].done_com !== 1'b1) begin
                errors++;
                $display("comm_done reached at %0t before master %0d finished", $time, m);
            end
        end
        if (rec_cyc[0][2] != rec_cyc[1][2])
            report_mismatch("comm start cycle m1", rec_cyc[1][2], rec_cyc[0][2]);
        @(posedge clk); // digits are registered
        #1;
        exp_hex0 = ~lit_segments(status[0].data_out[3:0]);
        exp_hex1 = ~lit_segments(status[0].data_out[7:4]);
        if (hex0 !== exp_hex0) report_mismatch("hex0", hex0, exp_hex0);
        if (hex1 !== exp_hex1) report_mismatch("hex1", hex1, exp_hex1);
        sw = DATA_W'($urandom);
        @(posedge clk);
        #1;
        for (int m = 0; m < N_MASTERS; m++) begin
            if (cmd[m].address !== sw[ADDR_W-1:0])
                report_mismatch($sformatf("cmd[%0d].address", m), cmd[m].address, sw[ADDR_W-1:0]);
        end
        end_test("comm done", err0);
    endtask

    initial begin
        void'($urandom(32'hba0));
        {rstN, step, next_addr, comm_armed} = '0;
        sw = '0;
        status = '0;
        cycle = 0;
        errors = 0;
        tests_run = 0;
        apply_reset();
        check_reset_values();
        check_empty_session();
        apply_reset();
        run_full_session();
        check_length_clamp();
        check_comm_done();
        $display("tests run %0d, checks failed %0d", tests_run, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
